// File: mdu_macros.svh
`ifndef MDU_MACROS_SVH
`define MDU_MACROS_SVH

// Datapath width of the RV64 integer registers.
`define MDU_XLEN 64

// One result bit per cycle in both cores.
`define MDU_ITERATIONS 64

`endif

// File: mdu_pkg.sv
`default_nettype none

`include "mdu_macros.svh"

package mdu_pkg;

    // Register words.
    typedef logic [`MDU_XLEN-1:0] u64;
    typedef logic signed [`MDU_XLEN-1:0] i64;

    // Full-width product of two words.
    typedef logic [2*`MDU_XLEN-1:0] u128;

    // Encoding follows funct3 of the OP opcode with funct7 = 0000001.
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000, // Low word, sign agnostic.
        OP_MULH   = 3'b001, // High word, signed x signed.
        OP_MULHSU = 3'b010, // High word, signed x unsigned.
        OP_MULHU  = 3'b011, // High word, unsigned x unsigned.
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } mdu_op_t;

endpackage

`default_nettype wire

// File: multiplier_multicycle.sv
`default_nettype none

`include "mdu_macros.svh"

module multiplier_multicycle (
    input  logic         clk,
    input  logic         reset,
    input  logic         start,
    input  mdu_pkg::u64  a,
    input  mdu_pkg::u64  b,
    output logic         done,
    output mdu_pkg::u128 product
);
    import mdu_pkg::*;

    localparam int COUNT_W = $clog2(`MDU_ITERATIONS + 1);

    logic                 running;
    logic [COUNT_W-1:0]   count;
    u64                   mcand;
    logic [2*`MDU_XLEN:0] acc;      // Upper half plus carry, multiplier below.
    logic [`MDU_XLEN:0]   upper_sum;
    logic [2*`MDU_XLEN:0] acc_next;

    // One shift-add step.
    always_comb begin
        upper_sum = acc[2*`MDU_XLEN:`MDU_XLEN];
        if (acc[0]) begin
            upper_sum = upper_sum + {1'b0, mcand};
        end
        acc_next = {1'b0, upper_sum, acc[`MDU_XLEN-1:1]};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            count   <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                count   <= COUNT_W'(`MDU_ITERATIONS);
            end else if (running) begin
                count <= count - 1'b1;
                if (count == COUNT_W'(1)) begin
                    running <= 1'b0; // Last step on this edge.
                    done    <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            acc   <= {{(`MDU_XLEN + 1){1'b0}}, a};
            mcand <= b;
        end else if (running) begin
            acc <= acc_next;
        end
    end

    // Held until the next start.
    assign product = acc[2*`MDU_XLEN-1:0];

endmodule

`default_nettype wire

// File: divider_multicycle.sv
`default_nettype none

`include "mdu_macros.svh"

module divider_multicycle (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  mdu_pkg::u64 dividend,
    input  mdu_pkg::u64 divisor,
    output logic        done,
    output mdu_pkg::u64 quotient,
    output mdu_pkg::u64 remainder
);
    import mdu_pkg::*;

    localparam int COUNT_W = $clog2(`MDU_ITERATIONS + 1);

    logic                 running;
    logic [COUNT_W-1:0]   count;
    u64                   rem;     // Partial remainder.
    u64                   quo;     // Dividend bits out, quotient bits in.
    u64                   dvsr;
    logic [`MDU_XLEN:0]   shifted;
    logic [`MDU_XLEN+1:0] diff;
    logic                 fits;

    // Trial subtraction of one restoring step.
    always_comb begin
        shifted = {rem, quo[`MDU_XLEN-1]};
        diff    = {1'b0, shifted} - {2'b00, dvsr};
        fits    = ~diff[`MDU_XLEN+1];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            count   <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                count   <= COUNT_W'(`MDU_ITERATIONS);
            end else if (running) begin
                count <= count - 1'b1;
                if (count == COUNT_W'(1)) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // A zero divisor always fits, so the quotient fills with ones
    // and the remainder collects the dividend.
    always_ff @(posedge clk) begin
        if (start) begin
            rem  <= '0;
            quo  <= dividend;
            dvsr <= divisor;
        end else if (running) begin
            if (fits) begin
                rem <= diff[`MDU_XLEN-1:0];
                quo <= {quo[`MDU_XLEN-2:0], 1'b1};
            end else begin
                rem <= shifted[`MDU_XLEN-1:0]; // Restore.
                quo <= {quo[`MDU_XLEN-2:0], 1'b0};
            end
        end
    end

    assign quotient  = quo;
    assign remainder = rem;

endmodule

`default_nettype wire

// File: mdu_control.sv
`default_nettype none

`include "mdu_macros.svh"

module mdu_control (
    input  logic             clk,
    input  logic             reset,
    input  logic             valid,
    input  mdu_pkg::mdu_op_t op,
    input  mdu_pkg::u64      a,
    input  mdu_pkg::u64      b,
    input  logic             mul_done,
    input  mdu_pkg::u128     mul_product,
    input  logic             div_done,
    input  mdu_pkg::u64      div_quotient,
    input  mdu_pkg::u64      div_remainder,
    output logic             busy,
    output logic             done,
    output logic             mul_start,
    output logic             div_start,
    output mdu_pkg::u64      mul_a,
    output mdu_pkg::u64      mul_b,
    output mdu_pkg::u64      div_dividend,
    output mdu_pkg::u64      div_divisor,
    output mdu_pkg::u64      result
);
    import mdu_pkg::*;

    logic    accept;
    logic    a_signed;
    logic    b_signed;
    logic    is_div;
    logic    a_neg;
    logic    b_neg;
    logic    neg_in;
    u64      mag_a_in;
    u64      mag_b_in;

    mdu_op_t op_q;
    u64      mag_a;
    u64      mag_b;
    logic    neg_q;
    logic    div_zero_q;

    u128     product_fixed;
    u64      quotient_fixed;
    u64      remainder_fixed;
    u64      dividend_orig;
    u64      result_next;

    assign accept = valid && !busy; // Strobes while busy are dropped.

    // Operand decode.
    always_comb begin
        a_signed = 1'b0;
        b_signed = 1'b0;
        case (op)
            OP_MULH, OP_DIV, OP_REM: begin
                a_signed = 1'b1;
                b_signed = 1'b1;
            end
            OP_MULHSU: a_signed = 1'b1;
            default: ;
        endcase
        is_div   = op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
        a_neg    = a_signed && (i64'(a) < 0);
        b_neg    = b_signed && (i64'(b) < 0);
        mag_a_in = a_neg ? -a : a;
        mag_b_in = b_neg ? -b : b; // Most negative maps onto itself.
        if (op == OP_REM) begin
            neg_in = a_neg; // Remainder follows the dividend.
        end else begin
            neg_in = a_neg ^ b_neg;
        end
    end

    // Sign fixup and result select.
    always_comb begin
        product_fixed   = neg_q ? -mul_product : mul_product;
        quotient_fixed  = neg_q ? -div_quotient : div_quotient;
        remainder_fixed = neg_q ? -div_remainder : div_remainder;
        dividend_orig   = neg_q ? -mag_a : mag_a;
        case (op_q)
            OP_MUL: result_next = product_fixed[`MDU_XLEN-1:0];
            OP_MULH, OP_MULHSU, OP_MULHU: begin
                result_next = product_fixed[2*`MDU_XLEN-1:`MDU_XLEN];
            end
            OP_DIV, OP_DIVU: result_next = div_zero_q ? '1 : quotient_fixed;
            default: result_next = div_zero_q ? dividend_orig : remainder_fixed;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            mul_start <= 1'b0;
            div_start <= 1'b0;
            result    <= '0;
        end else begin
            done      <= 1'b0;
            mul_start <= 1'b0;
            div_start <= 1'b0;
            if (accept) begin
                busy      <= 1'b1;
                mul_start <= !is_div;
                div_start <= is_div;
            end else if (busy && (mul_done || div_done)) begin
                busy   <= 1'b0;
                done   <= 1'b1;
                result <= result_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q       <= op;
            mag_a      <= mag_a_in;
            mag_b      <= mag_b_in;
            neg_q      <= neg_in;
            div_zero_q <= (b == '0);
        end
    end

    // Only the started core uses these magnitudes.
    assign mul_a        = mag_a;
    assign mul_b        = mag_b;
    assign div_dividend = mag_a;
    assign div_divisor  = mag_b;

endmodule

`default_nettype wire

// File: mdu_top.sv
`default_nettype none

module mdu_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             valid,
    input  mdu_pkg::mdu_op_t op,
    input  mdu_pkg::u64      a,
    input  mdu_pkg::u64      b,
    output logic             busy,
    output logic             done,
    output mdu_pkg::u64      result
);
    import mdu_pkg::*;

    logic mul_start;
    logic mul_done;
    u64   mul_a;
    u64   mul_b;
    u128  mul_product;
    logic div_start;
    logic div_done;
    u64   div_dividend;
    u64   div_divisor;
    u64   div_quotient;
    u64   div_remainder;

    mdu_control mdu_control_inst (
        .clk           (clk),
        .reset         (reset),
        .valid         (valid),
        .op            (op),
        .a             (a),
        .b             (b),
        .mul_done      (mul_done),
        .mul_product   (mul_product),
        .div_done      (div_done),
        .div_quotient  (div_quotient),
        .div_remainder (div_remainder),
        .busy          (busy),
        .done          (done),
        .mul_start     (mul_start),
        .div_start     (div_start),
        .mul_a         (mul_a),
        .mul_b         (mul_b),
        .div_dividend  (div_dividend),
        .div_divisor   (div_divisor),
        .result        (result)
    );

    multiplier_multicycle multiplier_multicycle_inst (
        .clk     (clk),
        .reset   (reset),
        .start   (mul_start),
        .a       (mul_a),
        .b       (mul_b),
        .done    (mul_done),
        .product (mul_product)
    );

    divider_multicycle divider_multicycle_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .dividend  (div_dividend),
        .divisor   (div_divisor),
        .done      (div_done),
        .quotient  (div_quotient),
        .remainder (div_remainder)
    );

endmodule

`default_nettype wire

// File: mdu_tb.sv
`default_nettype none

module mdu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mdu_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int LATENCY        = 66;
    localparam int MUL_RANDOM     = 40;
    localparam int DIV_RANDOM     = 48;
    localparam logic [63:0] LFSR_SEED = 64'd17319;
    localparam logic [63:0] LFSR_TAPS = 64'hD800_0000_0000_0000; // x^64+x^63+x^61+x^60+1.
    localparam u64 MOST_NEG = 64'h8000_0000_0000_0000;

    logic    clk;
    logic    reset;
    logic    valid;
    mdu_op_t op;
    u64      a;
    u64      b;
    logic    busy;
    logic    done;
    u64      result;

    logic [63:0] lfsr_state;
    int          cycle_count = 0;
    int          issued = 0;
    int          completed = 0;
    int          checks_passed = 0;
    int          checks_failed = 0;
    int          test_checks_base = 0;
    int          test_fail_base = 0;
    bit          timed_out = 1'b0;
    string       current_test = "reset";
    u64          exp_result_q[$];
    int          exp_edge_q[$];
    string       exp_name_q[$];

    mdu_top mdu_top_inst (
        .clk    (clk),
        .reset  (reset),
        .valid  (valid),
        .op     (op),
        .a      (a),
        .b      (b),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [63:0] lfsr_step(input logic [63:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output u64 v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // Corner values show up in three of eight picks.
    task automatic pick_operand(output u64 v);
        u64 sel;
        take_bits(3, sel);
        case (sel[2:0])
            3'd0: v = '0;
            3'd1: v = '1;
            3'd2: v = MOST_NEG;
            default: take_bits(64, v);
        endcase
    endtask

    // RISC-V M rules on sign- or zero-extended 128-bit operands.
    function automatic u64 ref_mdu(input mdu_op_t o, input u64 x, input u64 y);
        logic signed [127:0] sx;
        logic signed [127:0] sy;
        logic signed [127:0] ux;
        logic signed [127:0] uy;
        logic signed [127:0] wide;
        sx = {{64{x[63]}}, x};
        sy = {{64{y[63]}}, y};
        ux = {64'd0, x};
        uy = {64'd0, y};
        if (y == '0 && o inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU}) begin
            return (o inside {OP_DIV, OP_DIVU}) ? '1 : x; // Divide by zero.
        end
        case (o)
            OP_MUL, OP_MULH: wide = sx * sy;
            OP_MULHSU:       wide = sx * uy;
            OP_MULHU:        wide = ux * uy;
            OP_DIV:          wide = sx / sy;
            OP_DIVU:         wide = ux / uy;
            OP_REM:          wide = sx % sy;
            default:         wide = ux % uy;
        endcase
        if (o inside {OP_MULH, OP_MULHSU, OP_MULHU}) begin
            return wide[127:64];
        end
        return wide[63:0];
    endfunction

    task automatic check_value(input string name, input u64 expected, input u64 actual);
        bit ok;
        ok = (actual === expected);
        assert (ok) else begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
        end
        if (ok) checks_passed++;
        else checks_failed++;
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        bit ok;
        ok = (actual == expected);
        assert (ok) else begin
            $display("Error: %s expected %0d actual %0d", name, expected, actual);
        end
        if (ok) checks_passed++;
        else checks_failed++;
    endtask

    task automatic begin_test(input string name);
        current_test     = name;
        test_checks_base = checks_passed + checks_failed;
        test_fail_base   = checks_failed;
    endtask

    task automatic end_test();
        int errs;
        int total;
        errs  = checks_failed - test_fail_base;
        total = checks_passed + checks_failed - test_checks_base;
        $display("%s: %s, %0d checks, %0d errors", current_test,
                 (errs == 0) ? "ok" : "failed", total, errs);
    endtask

    task automatic issue_op(input mdu_op_t o, input u64 x, input u64 y);
        @(negedge clk);
        op    = o;
        a     = x;
        b     = y;
        valid = 1'b1;
        exp_result_q.push_back(ref_mdu(o, x, y));
        exp_edge_q.push_back(cycle_count + 1); // Edge that samples valid.
        exp_name_q.push_back($sformatf("%s %s a=%h b=%h", current_test, o.name(), x, y));
        issued++;
        @(negedge clk);
        valid = 1'b0;
    endtask

    task automatic wait_complete();
        int waited;
        waited = 0;
        while (completed != issued && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (completed != issued) begin
            $display("Timeout: %s saw no done pulse within %0d cycles",
                     current_test, TIMEOUT_CYCLES);
            checks_failed++;
            timed_out = 1'b1;
        end
    endtask

    task automatic run_op(input mdu_op_t o, input u64 x, input u64 y);
        issue_op(o, x, y);
        wait_complete();
    endtask

    // Compares every done pulse against the oldest expectation.
    always @(negedge clk) begin
        if (!reset && done) begin
            assert (exp_result_q.size() != 0) else begin
                $display("Unexpected done pulse with no operation in flight during %s",
                         current_test);
            end
            if (exp_result_q.size() == 0) begin
                checks_failed++;
            end else begin
                check_value(exp_name_q[0], exp_result_q[0], result);
                check_count({exp_name_q[0], " latency"}, LATENCY, cycle_count - exp_edge_q[0]);
                exp_result_q.delete(0);
                exp_edge_q.delete(0);
                exp_name_q.delete(0);
                completed++;
            end
        end
    end

    task automatic run_reset_test();
        begin_test("reset");
        check_count("reset busy", 0, int'(busy));
        check_count("reset done", 0, int'(done));
        check_value("reset result", '0, result);
        end_test();
    endtask

    task automatic run_multiply_test();
        u64 corners [3];
        u64 x;
        u64 y;
        u64 r;
        int i;
        int j;
        int k;
        begin_test("multiply");
        corners[0] = '0;
        corners[1] = '1;
        corners[2] = MOST_NEG;
        for (k = 0; k < 4 && !timed_out; k++) begin
            for (i = 0; i < 3 && !timed_out; i++) begin
                for (j = 0; j < 3 && !timed_out; j++) begin
                    run_op(mdu_op_t'(k[2:0]), corners[i], corners[j]);
                end
            end
        end
        for (i = 0; i < MUL_RANDOM && !timed_out; i++) begin
            take_bits(2, r);
            pick_operand(x);
            pick_operand(y);
            run_op(mdu_op_t'({1'b0, r[1:0]}), x, y);
        end
        end_test();
    endtask

    task automatic run_divide_test();
        u64 dvd [4];
        u64 dvs [4];
        u64 x;
        u64 y;
        u64 r;
        int i;
        int k;
        begin_test("divide");
        dvd[0] = MOST_NEG; // Overflow case.
        dvs[0] = '1;
        dvd[1] = -64'd7;
        dvs[1] = 64'd2;
        dvd[2] = 64'd7;
        dvs[2] = -64'd2;
        dvd[3] = -64'd7;
        dvs[3] = -64'd2;
        for (k = 4; k < 8 && !timed_out; k++) begin
            for (i = 0; i < 4 && !timed_out; i++) begin
                run_op(mdu_op_t'(k[2:0]), dvd[i], dvs[i]);
            end
        end
        for (i = 0; i < DIV_RANDOM && !timed_out; i++) begin
            take_bits(2, r);
            pick_operand(x);
            pick_operand(y);
            run_op(mdu_op_t'({1'b1, r[1:0]}), x, y);
        end
        end_test();
    endtask

    task automatic run_div_zero_test();
        u64 dvd [4];
        int i;
        int k;
        begin_test("div_zero");
        dvd[0] = '0;
        dvd[1] = MOST_NEG;
        dvd[2] = '1;
        take_bits(64, dvd[3]);
        for (k = 4; k < 8 && !timed_out; k++) begin
            for (i = 0; i < 4 && !timed_out; i++) begin
                run_op(mdu_op_t'(k[2:0]), dvd[i], '0);
            end
        end
        end_test();
    endtask

    task automatic run_timing_test();
        u64 x;
        u64 y;
        int i;
        int busy_cycles;
        begin_test("timing");
        take_bits(64, x);
        take_bits(64, y);
        issue_op(OP_DIVU, x, y);
        repeat (10) @(negedge clk);
        check_count("timing busy at second strobe", 1, int'(busy));
        op    = OP_MUL; // Must be dropped.
        a     = y;
        b     = ~x;
        valid = 1'b1;
        @(negedge clk);
        valid = 1'b0;
        wait_complete();
        busy_cycles = 0;
        for (i = 0; i < LATENCY + 10; i++) begin
            @(negedge clk);
            if (busy) busy_cycles++;
        end
        check_count("timing busy cycles after single done", 0, busy_cycles);
        if (!timed_out) run_op(OP_MULHU, x, y);
        end_test();
    endtask

    initial begin
        reset      = 1'b1;
        valid      = 1'b0;
        op         = OP_MUL;
        a          = '0;
        b          = '0;
        lfsr_state = LFSR_SEED;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        run_reset_test();
        if (!timed_out) run_multiply_test();
        if (!timed_out) run_divide_test();
        if (!timed_out) run_div_zero_test();
        if (!timed_out) run_timing_test();
        $display("Checks passed: %0d, failed: %0d", checks_passed, checks_failed);
        if (checks_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mdu.f
+incdir+.
mdu_pkg.sv
multiplier_multicycle.sv
divider_multicycle.sv
mdu_control.sv
mdu_top.sv
mdu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mdu_tb
FILELIST  ?= mdu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := mdu_macros.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail.
run: compile
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
